// ==== fetch_pkg.sv ====
/*
 * Instruction fetch shared definitions
 * Address and instruction word type, source select, per-fetch attribute
 * record and the default address map
 */
`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////
    // Basic types
    typedef logic [31:0] xlen_t;

    typedef enum logic {
        SRC_LMEM = 1'b0,
        SRC_BUS  = 1'b1
    } fetch_src_e;

    // One record per fetch in flight
    typedef struct packed {
        logic       addr_valid;
        fetch_src_e src;
        xlen_t      pc;
    } fetch_attr_t;

    //////////////////////////////////////////////////
    // Default address map
    localparam xlen_t DEFAULT_RESET_VEC  = 32'h0000_0000;

    localparam xlen_t DEFAULT_LOCAL_BASE = 32'h0000_0000;
    localparam xlen_t DEFAULT_LOCAL_HIGH = 32'h0000_0FFF;

    localparam xlen_t DEFAULT_BUS_BASE   = 32'h8000_0000;
    localparam xlen_t DEFAULT_BUS_HIGH   = 32'h8000_0FFF;

    // Most fetches in flight
    localparam int DEFAULT_FIFO_DEPTH = 2;

endpackage

`default_nettype wire

// ==== fetch_pc_gen.sv ====
/*
 * Fetch PC generation and request issue
 * Holds the PC, decodes it against the local and bus ranges and issues
 * one fetch per cycle when the rest of the unit can accept it
 */
`default_nettype none

module fetch_pc_gen #(
    parameter fetch_pkg::xlen_t RESET_VEC  = fetch_pkg::DEFAULT_RESET_VEC,
    parameter fetch_pkg::xlen_t LOCAL_BASE = fetch_pkg::DEFAULT_LOCAL_BASE,
    parameter fetch_pkg::xlen_t LOCAL_HIGH = fetch_pkg::DEFAULT_LOCAL_HIGH,
    parameter fetch_pkg::xlen_t BUS_BASE   = fetch_pkg::DEFAULT_BUS_BASE,
    parameter fetch_pkg::xlen_t BUS_HIGH   = fetch_pkg::DEFAULT_BUS_HIGH
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  redirect,
    input  wire fetch_pkg::xlen_t      redirect_pc,
    input  wire logic                  hold,
    input  wire logic                  fifo_full,
    input  wire logic                  bus_idle,

    output logic                       issue,
    output fetch_pkg::xlen_t           issue_addr,
    output fetch_pkg::fetch_attr_t     issue_attr
);

    fetch_pkg::xlen_t pc;
    logic             hit_local;
    logic             hit_bus;
    logic             fault_pending;

    //////////////////////////////////////////////////
    // Program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (redirect) begin
            pc <= {redirect_pc[31:2], 2'b00};
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////
    // Address decode
    assign hit_local = (pc >= LOCAL_BASE) && (pc <= LOCAL_HIGH);
    assign hit_bus   = (pc >= BUS_BASE) && (pc <= BUS_HIGH);

    assign issue_addr       = pc;
    assign issue_attr.pc    = pc;
    assign issue_attr.addr_valid = hit_local | hit_bus;
    // Unmapped fetches default to the local source, never started
    assign issue_attr.src   = hit_bus ? fetch_pkg::SRC_BUS : fetch_pkg::SRC_LMEM;

    //////////////////////////////////////////////////
    // Fault hold
    // Stop fetching past an access fault until control redirects
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            fault_pending <= 1'b0;
        end else if (issue && !issue_attr.addr_valid) begin
            fault_pending <= 1'b1;
        end
    end

    assign issue = !fifo_full && bus_idle && !hold && !fault_pending && !redirect;

endmodule

`default_nettype wire

// ==== fetch_attr_fifo.sv ====
/*
 * Fetch attribute FIFO
 * Circular buffer of in-flight fetch records, plus the flush counter that
 * marks how many of them belong to a redirected-away path
 */
`default_nettype none

module fetch_attr_fifo #(
    parameter int FIFO_DEPTH = fetch_pkg::DEFAULT_FIFO_DEPTH
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  push,
    input  wire fetch_pkg::fetch_attr_t push_attr,
    input  wire logic                  pop,
    input  wire logic                  redirect,

    output logic                       full,
    output logic                       head_valid,
    output fetch_pkg::fetch_attr_t     head_attr,
    output logic                       flushing
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fetch_pkg::fetch_attr_t entries [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] inflight_count;
    logic [CNT_W-1:0] inflight_count_next;
    logic [CNT_W-1:0] flush_count;

    //////////////////////////////////////////////////
    // Storage and pointers
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_attr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // In-flight and flush counting
    assign inflight_count_next = inflight_count + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            inflight_count <= inflight_count_next;
        end
    end

    // Everything still in flight after a redirect is stale
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (redirect) begin
            flush_count <= inflight_count_next;
        end else if (pop && (flush_count != '0)) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    assign full       = (inflight_count == CNT_W'(FIFO_DEPTH));
    assign head_valid = (inflight_count != '0);
    assign head_attr  = entries[rd_ptr];
    assign flushing   = (flush_count != '0);

    pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> head_valid
    ) else $error("attribute FIFO popped while empty");

endmodule

`default_nettype wire

// ==== ibus_apb_master.sv ====
/*
 * APB read requester for instruction fetches
 * Runs setup and access phases for one read at a time and registers
 * the returned word for a single response cycle
 */
`default_nettype none

module ibus_apb_master (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  start,
    input  wire fetch_pkg::xlen_t      start_addr,

    input  wire fetch_pkg::xlen_t      prdata,
    input  wire logic                  pready,
    input  wire logic                  pslverr,

    output logic                       idle,
    output fetch_pkg::xlen_t           paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,

    output logic                       rsp_valid,
    output fetch_pkg::xlen_t           rsp_data,
    output logic                       rsp_err
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    logic [1:0] state;

    //////////////////////////////////////////////////
    // Transfer FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (start) state <= ST_SETUP;
                ST_SETUP:  state <= ST_ACCESS;
                ST_ACCESS: if (pready) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Address held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            paddr <= start_addr;
        end
    end

    assign idle    = (state == ST_IDLE);
    assign psel    = (state == ST_SETUP) || (state == ST_ACCESS);
    assign penable = (state == ST_ACCESS);
    assign pwrite  = 1'b0;

    //////////////////////////////////////////////////
    // Response register
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= penable && pready;
        end
    end

    always_ff @(posedge clk) begin
        if (penable && pready) begin
            rsp_data <= prdata;
            rsp_err  <= pslverr;
        end
    end

    // A start during a transfer would be dropped
    start_while_busy: assert property (
        @(posedge clk) disable iff (rst) start |-> idle
    ) else $error("APB fetch started while a transfer was running");

endmodule

`default_nettype wire

// ==== fetch_response.sv ====
/*
 * Fetch response selection
 * Matches returning data to the FIFO head, drops stale responses and
 * raises completions toward decode
 */
`default_nettype none

module fetch_response (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  head_valid,
    input  wire fetch_pkg::fetch_attr_t head_attr,
    input  wire logic                  flushing,

    input  wire fetch_pkg::xlen_t      lmem_rdata,
    input  wire logic                  bus_rsp_valid,
    input  wire fetch_pkg::xlen_t      bus_rsp_data,
    input  wire logic                  bus_rsp_err,
    input  wire logic                  lmem_issued,

    output logic                       pop,
    output logic                       fetch_valid,
    output fetch_pkg::xlen_t           fetch_pc,
    output fetch_pkg::xlen_t           fetch_instruction,
    output logic                       fetch_ok
);

    logic             lmem_rsp_valid;
    logic             head_is_bus;
    logic             head_data_valid;
    fetch_pkg::xlen_t selected_data;

    //////////////////////////////////////////////////
    // Local memory has a fixed one cycle latency
    always_ff @(posedge clk) begin
        if (rst) begin
            lmem_rsp_valid <= 1'b0;
        end else begin
            lmem_rsp_valid <= lmem_issued;
        end
    end

    //////////////////////////////////////////////////
    // Source select
    assign head_is_bus = (head_attr.src == fetch_pkg::SRC_BUS);

    assign head_data_valid = head_is_bus ? bus_rsp_valid : lmem_rsp_valid;
    assign selected_data   = head_is_bus ? bus_rsp_data : lmem_rdata;

    // Faulted entries carry no request, so they leave immediately
    assign pop = head_valid && (!head_attr.addr_valid || head_data_valid);

    assign fetch_ok = head_attr.addr_valid && !(head_is_bus && bus_rsp_err);

    //////////////////////////////////////////////////
    // Completion
    assign fetch_valid       = pop && !flushing;
    assign fetch_pc          = head_attr.pc;
    assign fetch_instruction = fetch_ok ? selected_data : '0;

    //////////////////////////////////////////////////
    // Assertions
    // Data returning unasked would pop the wrong record
    spurious_lmem_data: assert property (
        @(posedge clk) disable iff (rst)
        lmem_rsp_valid |-> (head_valid && head_attr.addr_valid &&
                            head_attr.src == fetch_pkg::SRC_LMEM)
    ) else $error("local memory data with no matching fetch");

    spurious_bus_data: assert property (
        @(posedge clk) disable iff (rst)
        bus_rsp_valid |-> (head_valid && head_attr.addr_valid &&
                           head_attr.src == fetch_pkg::SRC_BUS)
    ) else $error("APB data with no matching fetch");

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
/*
 * Instruction fetch unit top level
 * PC generation, attribute FIFO, response selection and the APB
 * requester, with a local memory port and an APB port
 */
`default_nettype none

module fetch_unit #(
    parameter fetch_pkg::xlen_t RESET_VEC  = fetch_pkg::DEFAULT_RESET_VEC,
    parameter fetch_pkg::xlen_t LOCAL_BASE = fetch_pkg::DEFAULT_LOCAL_BASE,
    parameter fetch_pkg::xlen_t LOCAL_HIGH = fetch_pkg::DEFAULT_LOCAL_HIGH,
    parameter fetch_pkg::xlen_t BUS_BASE   = fetch_pkg::DEFAULT_BUS_BASE,
    parameter fetch_pkg::xlen_t BUS_HIGH   = fetch_pkg::DEFAULT_BUS_HIGH,
    parameter int               FIFO_DEPTH = fetch_pkg::DEFAULT_FIFO_DEPTH
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Decode side
    output logic                       fetch_valid,
    output fetch_pkg::xlen_t           fetch_pc,
    output fetch_pkg::xlen_t           fetch_instruction,
    output logic                       fetch_ok,

    // Control side
    input  wire logic                  redirect,
    input  wire fetch_pkg::xlen_t      redirect_pc,
    input  wire logic                  hold,

    // Local instruction memory
    output logic                       lmem_en,
    output fetch_pkg::xlen_t           lmem_addr,
    input  wire fetch_pkg::xlen_t      lmem_rdata,

    // APB
    output fetch_pkg::xlen_t           paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    input  wire fetch_pkg::xlen_t      prdata,
    input  wire logic                  pready,
    input  wire logic                  pslverr
);

    logic                   issue;
    fetch_pkg::xlen_t       issue_addr;
    fetch_pkg::fetch_attr_t issue_attr;
    logic                   bus_start;
    logic                   bus_idle;
    logic                   fifo_full;
    logic                   fifo_pop;
    logic                   head_valid;
    fetch_pkg::fetch_attr_t head_attr;
    logic                   flushing;
    logic                   bus_rsp_valid;
    fetch_pkg::xlen_t       bus_rsp_data;
    logic                   bus_rsp_err;

    //////////////////////////////////////////////////
    // Request routing
    assign lmem_en   = issue && issue_attr.addr_valid && (issue_attr.src == fetch_pkg::SRC_LMEM);
    assign lmem_addr = issue_addr;
    assign bus_start = issue && issue_attr.addr_valid && (issue_attr.src == fetch_pkg::SRC_BUS);

    fetch_pc_gen #(
        .RESET_VEC  (RESET_VEC),
        .LOCAL_BASE (LOCAL_BASE),
        .LOCAL_HIGH (LOCAL_HIGH),
        .BUS_BASE   (BUS_BASE),
        .BUS_HIGH   (BUS_HIGH)
    ) u_pc_gen (
        .clk (clk), .rst (rst),
        .redirect (redirect), .redirect_pc (redirect_pc), .hold (hold),
        .fifo_full (fifo_full), .bus_idle (bus_idle),
        .issue (issue), .issue_addr (issue_addr), .issue_attr (issue_attr)
    );

    fetch_attr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_attr_fifo (
        .clk (clk), .rst (rst),
        .push (issue), .push_attr (issue_attr), .pop (fifo_pop), .redirect (redirect),
        .full (fifo_full), .head_valid (head_valid), .head_attr (head_attr),
        .flushing (flushing)
    );

    ibus_apb_master u_apb_master (
        .clk (clk), .rst (rst),
        .start (bus_start), .start_addr (issue_addr),
        .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .idle (bus_idle), .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .rsp_valid (bus_rsp_valid), .rsp_data (bus_rsp_data), .rsp_err (bus_rsp_err)
    );

    fetch_response u_response (
        .clk (clk), .rst (rst),
        .head_valid (head_valid), .head_attr (head_attr), .flushing (flushing),
        .lmem_rdata (lmem_rdata), .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_data (bus_rsp_data), .bus_rsp_err (bus_rsp_err), .lmem_issued (lmem_en),
        .pop (fifo_pop), .fetch_valid (fetch_valid), .fetch_pc (fetch_pc),
        .fetch_instruction (fetch_instruction), .fetch_ok (fetch_ok)
    );

endmodule

`default_nettype wire

// ==== tb_fetch_models.sv ====
/*
 * Testbench memory models
 * Local instruction memory with one cycle read latency and an APB
 * completer with random wait states
 */
`default_nettype none

module tb_lmem_model #(
    parameter fetch_pkg::xlen_t KEY = '0
) (
    input  wire logic             clk,
    input  wire logic             en,
    input  wire fetch_pkg::xlen_t addr,
    output fetch_pkg::xlen_t      rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        rdata = '0;
    end

    // Data shows up the cycle after the enable
    always @(posedge clk) begin
        if (en) begin
            rdata <= addr ^ KEY;
        end
    end

endmodule

module tb_apb_completer #(
    parameter fetch_pkg::xlen_t KEY = '0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire fetch_pkg::xlen_t paddr,
    output fetch_pkg::xlen_t      prdata,
    output logic                  pready,
    output logic                  pslverr
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned draw;
    int unsigned waits_left;

    initial begin
        prdata     = '0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        waits_left = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            pready     <= 1'b0;
            waits_left <= 0;
        end else if (psel && !penable) begin
            // Setup phase, 0 to 3 wait states for this read
            draw = $urandom % 4;
            if (draw == 0) begin
                pready <= 1'b1;
                prdata <= paddr ^ KEY;
            end else begin
                waits_left <= draw;
            end
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
            end else if (waits_left == 1) begin
                pready     <= 1'b1;
                prdata     <= paddr ^ KEY;
                waits_left <= 0;
            end else begin
                waits_left <= waits_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_fetch.sv ====
/*
 * Fetch unit testbench
 * Local, bus, redirect, fault and hold sequences checked against a
 * reference model of the expected PC stream
 */
`default_nettype none

module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned      SEED          = 32'h96821c60;
    localparam fetch_pkg::xlen_t INSTR_KEY     = 32'hC3A5_5A3C;
    localparam int               RESET_CYCLES  = 16;
    localparam int               LOCAL_FETCHES = 40;
    localparam int               BUS_FETCHES   = 20;
    localparam int               NUM_REDIRECTS = 8;
    localparam int               HOLD_CYCLES   = 40;
    localparam int               DRAIN_LIMIT   = 10;
    localparam int               BUS_WORST     = 7;
    localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * LOCAL_FETCHES + BUS_FETCHES * BUS_WORST
        + NUM_REDIRECTS * (8 + 4 * BUS_WORST) + 200 + 2 * (HOLD_CYCLES + 12 * BUS_WORST);
    localparam int TIMEOUT_CYCLES  = 4 * PLANNED_CYCLES;

    logic clk;
    logic rst;
    logic redirect;
    logic hold;
    logic fetch_valid;
    logic fetch_ok;
    logic lmem_en;
    logic psel;
    logic penable;
    logic pwrite;
    logic pready;
    logic pslverr;
    fetch_pkg::xlen_t redirect_pc;
    fetch_pkg::xlen_t fetch_pc;
    fetch_pkg::xlen_t fetch_instruction;
    fetch_pkg::xlen_t lmem_addr;
    fetch_pkg::xlen_t lmem_rdata;
    fetch_pkg::xlen_t paddr;
    fetch_pkg::xlen_t prdata;

    // Reference model state
    fetch_pkg::xlen_t exp_pc;
    logic             exp_ok;
    logic             fault_seen;
    int               hold_cycles;
    int               completion_count = 0;
    int               fault_count = 0;
    int               cycle_count = 0;

    always #2 clk = ~clk;

    fetch_unit u_dut (
        .clk (clk), .rst (rst),
        .fetch_valid (fetch_valid), .fetch_pc (fetch_pc),
        .fetch_instruction (fetch_instruction), .fetch_ok (fetch_ok),
        .redirect (redirect), .redirect_pc (redirect_pc), .hold (hold),
        .lmem_en (lmem_en), .lmem_addr (lmem_addr), .lmem_rdata (lmem_rdata),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .prdata (prdata), .pready (pready), .pslverr (pslverr)
    );

    tb_lmem_model #(.KEY (INSTR_KEY)) u_lmem (
        .clk (clk), .en (lmem_en), .addr (lmem_addr), .rdata (lmem_rdata)
    );

    tb_apb_completer #(.KEY (INSTR_KEY)) u_apb (
        .clk (clk), .rst (rst), .psel (psel), .penable (penable), .paddr (paddr),
        .prdata (prdata), .pready (pready), .pslverr (pslverr)
    );

    //////////////////////////////////////////////////
    // Reference and checks
    function automatic fetch_pkg::xlen_t instr_at(input fetch_pkg::xlen_t addr);
        return addr ^ INSTR_KEY;
    endfunction

    function automatic logic addr_mapped(input fetch_pkg::xlen_t addr);
        return ((addr >= fetch_pkg::DEFAULT_LOCAL_BASE) && (addr <= fetch_pkg::DEFAULT_LOCAL_HIGH))
            || ((addr >= fetch_pkg::DEFAULT_BUS_BASE) && (addr <= fetch_pkg::DEFAULT_BUS_HIGH));
    endfunction

    task automatic check_word(input string name, input fetch_pkg::xlen_t got,
                              input fetch_pkg::xlen_t expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
            $display("test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
            $display("test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("test failed");
        $fatal(1, "%s", what);
    endtask

    // Compare process, one completion per cycle at most
    always @(posedge clk) begin
        if (rst) begin
            exp_pc      = fetch_pkg::DEFAULT_RESET_VEC;
            fault_seen  = 1'b0;
            hold_cycles = 0;
        end else begin
            // Fetches only ever read over APB
            check_bit("pwrite", pwrite, 1'b0);
            if (fetch_valid) begin
                if (fault_seen) begin
                    report_error("completion after an access fault with no redirect");
                end
                if (hold_cycles > DRAIN_LIMIT) begin
                    report_error("completion while hold was high after the drain");
                end
                exp_ok = addr_mapped(exp_pc);
                check_word("fetch_pc", fetch_pc, exp_pc);
                check_bit("fetch_ok", fetch_ok, exp_ok);
                check_word("fetch_instruction", fetch_instruction,
                           exp_ok ? instr_at(exp_pc) : '0);
                if (!exp_ok) begin
                    fault_seen = 1'b1;
                    fault_count <= fault_count + 1;
                end
                exp_pc = exp_pc + 32'd4;
                completion_count <= completion_count + 1;
            end
            // Old path may still complete in the redirect cycle itself
            if (redirect) begin
                exp_pc     = redirect_pc;
                fault_seen = 1'b0;
            end
            hold_cycles = hold ? hold_cycles + 1 : 0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    task automatic wait_completions(input int n);
        int target;
        target = completion_count + n;
        while (completion_count < target) @(posedge clk);
    endtask

    task automatic do_redirect(input fetch_pkg::xlen_t target);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    initial begin
        fetch_pkg::xlen_t target;
        int               faults_before;
        clk         = 1'b0;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        hold        = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        wait_completions(LOCAL_FETCHES);

        do_redirect(fetch_pkg::DEFAULT_BUS_BASE);
        wait_completions(BUS_FETCHES);

        // Redirects shortly after a completion, with fetches in flight
        for (int i = 0; i < NUM_REDIRECTS; i++) begin
            repeat ($urandom % 4) @(posedge clk);
            if ($urandom % 2) begin
                target = fetch_pkg::DEFAULT_BUS_BASE + ($urandom % 256) * 4;
            end else begin
                target = fetch_pkg::DEFAULT_LOCAL_BASE + ($urandom % 512) * 4;
            end
            do_redirect(target);
            wait_completions(4);
        end

        // Run off the end of local memory
        faults_before = fault_count;
        do_redirect(fetch_pkg::DEFAULT_LOCAL_HIGH - 32'd7);
        while (fault_count == faults_before) @(posedge clk);
        repeat (30) @(posedge clk);
        do_redirect(32'h0000_0100);
        wait_completions(10);

        // Hold once on the local path, once on the bus
        for (int k = 0; k < 2; k++) begin
            if (k == 1) begin
                do_redirect(fetch_pkg::DEFAULT_BUS_BASE + 32'h200);
                wait_completions(2);
            end
            repeat ($urandom % 4) @(posedge clk);
            hold <= 1'b1;
            repeat (HOLD_CYCLES) @(posedge clk);
            hold <= 1'b0;
            wait_completions(10);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
fetch_pkg.sv
fetch_pc_gen.sv
fetch_attr_fifo.sv
ibus_apb_master.sv
fetch_response.sv
fetch_unit.sv
tb_fetch_models.sv
tb_fetch.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
